// File: common/fifo_settings.svh
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// Entries per channel as a power of two, 16 words
`define FIFO_DEPTH_LOG2 4

// Payload width of one stream word
`define FIFO_WIDTH 16

// Register stages between the write port and the memory
`define FIFO_WRITE_STAGES 1

// Cycles from an accepted pop to dataValid
// One for the address register, one for the memory output register
`define FIFO_READ_LATENCY 2

// Width of the merged-word counters
`define COUNT_WIDTH 16

`endif

// File: common/fifoPkg.sv
`default_nettype none

`include "fifo_settings.svh"

package fifoPkg;

    // One write port beat
    typedef struct packed {
        logic                   wrEn;
        logic [`FIFO_WIDTH-1:0] data;
    } fifoWrite_t;

    // Read-side status of one FIFO
    // usedw has one extra bit so a full FIFO reads 16
    typedef struct packed {
        logic                     empty;
        logic [`FIFO_DEPTH_LOG2:0] usedw;
    } fifoStatus_t;

    // Output stream word, tag is the source channel
    typedef struct packed {
        logic                   valid;
        logic                   tag;
        logic [`FIFO_WIDTH-1:0] data;
    } mergedWord_t;

endpackage

`default_nettype wire

// File: common/apbPkg.sv
`default_nettype none

package apbPkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apbResp_t;

    // Word offsets of the register map
    localparam logic [3:0] REG_CTRL   = 4'd0;
    localparam logic [3:0] REG_STATUS = 4'd1;
    localparam logic [3:0] REG_COUNT0 = 4'd2;
    localparam logic [3:0] REG_COUNT1 = 4'd3;

endpackage

`default_nettype wire

// File: fifo/fifoController.sv
`default_nettype none

`include "fifo_settings.svh"

module fifoController (
    input  logic                         rdclk,
    input  logic                         rdrst,
    input  logic                         writeEnable,
    input  logic                         readRequest,
    output logic                         isReading,
    output fifoPkg::fifoStatus_t         status,
    output logic [`FIFO_DEPTH_LOG2-1:0]  writeAddr,
    output logic [`FIFO_DEPTH_LOG2-1:0]  nextReadAddr,
    output logic                         readAddressStall
);

    // One wrap bit above the address so full and empty differ
    localparam int PtrWidth = `FIFO_DEPTH_LOG2 + 1;

    logic [PtrWidth-1:0] writePtr;
    logic [PtrWidth-1:0] writePtrD;
    logic [PtrWidth-1:0] readPtr;
    logic [PtrWidth-1:0] readPtrD;
    logic                rdrstD;
    logic                empty;

    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            writePtr <= '0;
        end else if (writeEnable) begin
            writePtr <= writePtr + 1'b1;
        end
    end

    // Pointers as seen from the opposite side, one cycle late
    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            writePtrD <= '0;
            readPtrD  <= '0;
        end else begin
            writePtrD <= writePtr;
            readPtrD  <= readPtr;
        end
    end

    always_ff @(posedge rdclk) begin
        rdrstD <= rdrst;
    end

    // The data behind writePtrD has already reached the memory
    assign empty = writePtrD == readPtr;

    // No pop in the preload cycle right after reset
    assign isReading = readRequest && !empty && !rdrstD;

    // Unstalled right after reset so the address register picks up entry 0
    assign readAddressStall = !(isReading || rdrstD);

    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            readPtr <= '0;
        end else if (isReading) begin
            readPtr <= readPtr + 1'b1;
        end
    end

    assign status.empty = empty;
    assign status.usedw = writePtr - readPtrD;

    assign writeAddr    = writePtr[`FIFO_DEPTH_LOG2-1:0];
    assign nextReadAddr = readPtr[`FIFO_DEPTH_LOG2-1:0];

endmodule

`default_nettype wire

// File: fifo/fifoMemory.sv
`default_nettype none

`include "fifo_settings.svh"

module fifoMemory (
    input  logic                         rdclk,
    input  logic                         writeEnable,
    input  logic [`FIFO_DEPTH_LOG2-1:0]  writeAddr,
    input  logic [`FIFO_WIDTH-1:0]       dataIn,
    input  logic                         readAddressStall,
    input  logic [`FIFO_DEPTH_LOG2-1:0]  readAddr,
    output logic [`FIFO_WIDTH-1:0]       dataOut
);

    logic [`FIFO_WIDTH-1:0]      mem [2**`FIFO_DEPTH_LOG2];
    logic [`FIFO_DEPTH_LOG2-1:0] readAddrReg;

    always_ff @(posedge rdclk) begin
        if (writeEnable) begin
            mem[writeAddr] <= dataIn;
        end
    end

    // Address register holds its value while stalled
    always_ff @(posedge rdclk) begin
        if (!readAddressStall) begin
            readAddrReg <= readAddr;
        end
    end

    // Output register, second cycle of read latency
    always_ff @(posedge rdclk) begin
        dataOut <= mem[readAddrReg];
    end

endmodule

`default_nettype wire

// File: fifo/fastFifo.sv
`default_nettype none

`include "fifo_settings.svh"

module fastFifo (
    input  logic                   rdclk,
    input  logic                   rdrst,
    input  fifoPkg::fifoWrite_t    wrPort,
    input  logic                   pop,
    output fifoPkg::fifoStatus_t   status,
    output logic [`FIFO_WIDTH-1:0] dataOut,
    output logic                   dataValid
);

    logic                        isReading;
    logic                        readAddressStall;
    logic [`FIFO_DEPTH_LOG2-1:0] writeAddr;
    logic [`FIFO_DEPTH_LOG2-1:0] nextReadAddr;

    logic                        wrEnPipe   [`FIFO_WRITE_STAGES];
    logic [`FIFO_DEPTH_LOG2-1:0] wrAddrPipe [`FIFO_WRITE_STAGES];
    logic [`FIFO_WIDTH-1:0]      wrDataPipe [`FIFO_WRITE_STAGES];
    logic                        validPipe  [`FIFO_READ_LATENCY];

    fifoController u_controller (
        .rdclk            (rdclk),
        .rdrst            (rdrst),
        .writeEnable      (wrPort.wrEn),
        .readRequest      (pop),
        .isReading        (isReading),
        .status           (status),
        .writeAddr        (writeAddr),
        .nextReadAddr     (nextReadAddr),
        .readAddressStall (readAddressStall)
    );

    // Write side delay, enable is control and gets reset
    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            for (int i = 0; i < `FIFO_WRITE_STAGES; i++) begin
                wrEnPipe[i] <= 1'b0;
            end
        end else begin
            wrEnPipe[0] <= wrPort.wrEn;
            for (int i = 1; i < `FIFO_WRITE_STAGES; i++) begin
                wrEnPipe[i] <= wrEnPipe[i-1];
            end
        end
    end

    always_ff @(posedge rdclk) begin
        wrAddrPipe[0] <= writeAddr;
        wrDataPipe[0] <= wrPort.data;
        for (int i = 1; i < `FIFO_WRITE_STAGES; i++) begin
            wrAddrPipe[i] <= wrAddrPipe[i-1];
            wrDataPipe[i] <= wrDataPipe[i-1];
        end
    end

    fifoMemory u_memory (
        .rdclk            (rdclk),
        .writeEnable      (wrEnPipe[`FIFO_WRITE_STAGES-1]),
        .writeAddr        (wrAddrPipe[`FIFO_WRITE_STAGES-1]),
        .dataIn           (wrDataPipe[`FIFO_WRITE_STAGES-1]),
        .readAddressStall (readAddressStall),
        .readAddr         (nextReadAddr),
        .dataOut          (dataOut)
    );

    // Valid follows the accepted pop through the memory latency
    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            for (int i = 0; i < `FIFO_READ_LATENCY; i++) begin
                validPipe[i] <= 1'b0;
            end
        end else begin
            validPipe[0] <= isReading;
            for (int i = 1; i < `FIFO_READ_LATENCY; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    assign dataValid = validPipe[`FIFO_READ_LATENCY-1];

endmodule

`default_nettype wire

// File: logic/streamMerger.sv
`default_nettype none

`include "fifo_settings.svh"

module streamMerger (
    input  logic                    rdclk,
    input  logic                    rdrst,
    input  fifoPkg::fifoStatus_t    status0,
    input  fifoPkg::fifoStatus_t    status1,
    input  logic [`FIFO_WIDTH-1:0]  data0,
    input  logic [`FIFO_WIDTH-1:0]  data1,
    input  logic                    valid0,
    input  logic                    valid1,
    input  logic                    enable,
    input  logic [1:0]              mask,
    output logic                    pop0,
    output logic                    pop1,
    output fifoPkg::mergedWord_t    outWord,
    output logic [`COUNT_WIDTH-1:0] count0,
    output logic [`COUNT_WIDTH-1:0] count1
);

    logic ready0;
    logic ready1;
    logic pick1;
    logic lastPick1;
    logic req0;
    logic req1;

    assign ready0 = enable && mask[0] && !status0.empty;
    assign ready1 = enable && mask[1] && !status1.empty;

    // Both ready: take the other one than last time
    assign pick1 = (ready0 && ready1) ? !lastPick1 : ready1;

    // Decision is registered, pop happens next cycle
    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            req0      <= 1'b0;
            req1      <= 1'b0;
            lastPick1 <= 1'b1;
        end else begin
            req0 <= ready0 && !pick1;
            req1 <= pick1;
            if (ready0 || ready1) begin
                lastPick1 <= pick1;
            end
        end
    end

    // Current enable, mask and empty still gate the request
    assign pop0 = req0 && ready0;
    assign pop1 = req1 && ready1;

    // Only one pop per cycle, so at most one valid returns at a time
    assign outWord.valid = valid0 || valid1;
    assign outWord.tag   = valid1;
    assign outWord.data  = valid1 ? data1 : data0;

    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            count0 <= '0;
            count1 <= '0;
        end else begin
            if (valid0) begin
                count0 <= count0 + 1'b1;
            end
            if (valid1) begin
                count1 <= count1 + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/apbRegs.sv
`default_nettype none

`include "fifo_settings.svh"

module apbRegs (
    input  logic                    rdclk,
    input  logic                    rdrst,
    input  apbPkg::apbReq_t         apbIn,
    output apbPkg::apbResp_t        apbOut,
    input  fifoPkg::fifoStatus_t    status0,
    input  fifoPkg::fifoStatus_t    status1,
    input  logic [`COUNT_WIDTH-1:0] count0,
    input  logic [`COUNT_WIDTH-1:0] count1,
    output logic                    enable,
    output logic [1:0]              mask
);

    import apbPkg::*;

    logic access;
    logic addrOk;
    logic ctrlWrite;

    // Access phase, no wait states
    assign access    = apbIn.psel && apbIn.penable;
    assign addrOk    = apbIn.paddr <= REG_COUNT1;
    assign ctrlWrite = access && apbIn.pwrite && (apbIn.paddr == REG_CTRL);

    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            enable <= 1'b0;
            mask   <= 2'b00;
        end else if (ctrlWrite) begin
            enable <= apbIn.pwdata[0];
            mask   <= apbIn.pwdata[2:1];
        end
    end

    assign apbOut.pready  = access;
    // Bad offset, or a write anywhere but the control register
    assign apbOut.pslverr = access && (!addrOk || (apbIn.pwrite && !ctrlWrite));

    // Status layout: channel 1 occupancy in the upper half
    always_comb begin
        case (apbIn.paddr)
            REG_CTRL:   apbOut.prdata = {29'd0, mask, enable};
            REG_STATUS: apbOut.prdata = {16'(status1.usedw), 16'(status0.usedw)};
            REG_COUNT0: apbOut.prdata = 32'(count0);
            REG_COUNT1: apbOut.prdata = 32'(count1);
            default:    apbOut.prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mergeTop.sv
`default_nettype none

`include "fifo_settings.svh"

module mergeTop (
    input  logic                 rdclk,
    input  logic                 rdrst,
    input  fifoPkg::fifoWrite_t  wrPort0,
    input  fifoPkg::fifoWrite_t  wrPort1,
    input  apbPkg::apbReq_t      apbIn,
    output apbPkg::apbResp_t     apbOut,
    output fifoPkg::mergedWord_t outWord
);

    import fifoPkg::*;

    fifoStatus_t             status0;
    fifoStatus_t             status1;
    logic [`FIFO_WIDTH-1:0]  data0;
    logic [`FIFO_WIDTH-1:0]  data1;
    logic                    valid0;
    logic                    valid1;
    logic                    pop0;
    logic                    pop1;
    logic                    enable;
    logic [1:0]              mask;
    logic [`COUNT_WIDTH-1:0] count0;
    logic [`COUNT_WIDTH-1:0] count1;

    fastFifo u_fifo0 (
        .rdclk     (rdclk),
        .rdrst     (rdrst),
        .wrPort    (wrPort0),
        .pop       (pop0),
        .status    (status0),
        .dataOut   (data0),
        .dataValid (valid0)
    );

    fastFifo u_fifo1 (
        .rdclk     (rdclk),
        .rdrst     (rdrst),
        .wrPort    (wrPort1),
        .pop       (pop1),
        .status    (status1),
        .dataOut   (data1),
        .dataValid (valid1)
    );

    streamMerger u_merger (
        .rdclk   (rdclk),
        .rdrst   (rdrst),
        .status0 (status0),
        .status1 (status1),
        .data0   (data0),
        .data1   (data1),
        .valid0  (valid0),
        .valid1  (valid1),
        .enable  (enable),
        .mask    (mask),
        .pop0    (pop0),
        .pop1    (pop1),
        .outWord (outWord),
        .count0  (count0),
        .count1  (count1)
    );

    apbRegs u_regs (
        .rdclk   (rdclk),
        .rdrst   (rdrst),
        .apbIn   (apbIn),
        .apbOut  (apbOut),
        .status0 (status0),
        .status1 (status1),
        .count0  (count0),
        .count1  (count1),
        .enable  (enable),
        .mask    (mask)
    );

endmodule

`default_nettype wire

// File: bench/merge_sva.sv
`default_nettype none

`include "fifo_settings.svh"

module mergeCheck (
    input logic                 rdclk,
    input logic                 rdrst,
    input fifoPkg::fifoWrite_t  wrPort0,
    input fifoPkg::fifoWrite_t  wrPort1,
    input apbPkg::apbReq_t      apbIn,
    input apbPkg::apbResp_t     apbOut,
    input fifoPkg::mergedWord_t outWord
);

    timeunit 1ns;
    timeprecision 1ps;

    import apbPkg::*;

    // Cycles after a control write until a closed channel must be silent
    localparam int BlockDelay = 3;
    localparam int StallLimit = 24;

    int errors = 0;

    logic [`COUNT_WIDTH-1:0] written0;
    logic [`COUNT_WIDTH-1:0] written1;
    logic [`COUNT_WIDTH-1:0] seen0;
    logic [`COUNT_WIDTH-1:0] seen1;
    logic [`COUNT_WIDTH-1:0] pending0;
    logic [`COUNT_WIDTH-1:0] pending1;
    logic [`FIFO_WIDTH-1:0]  wordLog0 [256];
    logic [`FIFO_WIDTH-1:0]  wordLog1 [256];
    logic [`FIFO_WIDTH-1:0]  expectData;
    logic                    enQ;
    logic [1:0]              maskQ;
    logic                    everEnabled;
    logic [1:0]              ctrlAge;
    logic                    open0;
    logic                    open1;
    logic                    lastTag;
    logic                    expectAlt;
    logic                    starved0;
    logic                    starved1;
    logic [4:0]              stall0;
    logic [4:0]              stall1;
    logic                    access;
    logic                    ctrlWrite;
    logic                    expectErr;

    assign access    = apbIn.psel && apbIn.penable;
    assign ctrlWrite = access && apbIn.pwrite && apbIn.paddr == REG_CTRL;
    // Offsets above 3 and writes to read-only registers are illegal
    assign expectErr = apbIn.paddr > REG_COUNT1 || (apbIn.pwrite && apbIn.paddr != REG_CTRL);

    // Words written and not yet seen on the output
    // Words still in flight count as pending
    assign pending0 = written0 - seen0;
    assign pending1 = written1 - seen1;

    assign open0 = enQ && maskQ[0];
    assign open1 = enQ && maskQ[1];

    assign starved0 = open0 && pending0 != 0 && !(outWord.valid && !outWord.tag);
    assign starved1 = open1 && pending1 != 0 && !(outWord.valid && outWord.tag);

    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            written0 <= '0;
            written1 <= '0;
            seen0    <= '0;
            seen1    <= '0;
        end else begin
            if (wrPort0.wrEn) begin
                written0 <= written0 + 1'b1;
            end
            if (wrPort1.wrEn) begin
                written1 <= written1 + 1'b1;
            end
            if (outWord.valid && !outWord.tag) begin
                seen0 <= seen0 + 1'b1;
            end
            if (outWord.valid && outWord.tag) begin
                seen1 <= seen1 + 1'b1;
            end
        end
    end

    // Every written payload, kept by its position in the channel
    always_ff @(posedge rdclk) begin
        if (wrPort0.wrEn) begin
            wordLog0[written0[7:0]] <= wrPort0.data;
        end
        if (wrPort1.wrEn) begin
            wordLog1[written1[7:0]] <= wrPort1.data;
        end
    end

    assign expectData = outWord.tag ? wordLog1[seen1[7:0]] : wordLog0[seen0[7:0]];

    // Shadow of the control register
    // ctrlAge counts cycles since the last control write and stops at BlockDelay
    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            enQ         <= 1'b0;
            maskQ       <= 2'b00;
            everEnabled <= 1'b0;
            ctrlAge     <= 2'(BlockDelay);
        end else if (ctrlWrite) begin
            enQ         <= apbIn.pwdata[0];
            maskQ       <= apbIn.pwdata[2:1];
            everEnabled <= everEnabled || apbIn.pwdata[0];
            ctrlAge     <= 2'd1;
        end else if (ctrlAge != 2'(BlockDelay)) begin
            ctrlAge <= ctrlAge + 1'b1;
        end
    end

    // Next word must switch channel while both have two or more waiting
    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            lastTag   <= 1'b0;
            expectAlt <= 1'b0;
        end else if (ctrlWrite) begin
            expectAlt <= 1'b0;
        end else if (outWord.valid) begin
            lastTag   <= outWord.tag;
            expectAlt <= enQ && maskQ == 2'b11 && pending0 >= 2 && pending1 >= 2;
        end
    end

    always_ff @(posedge rdclk) begin
        if (rdrst) begin
            stall0 <= '0;
            stall1 <= '0;
        end else begin
            stall0 <= !starved0 ? '0 : (stall0 == '1 ? stall0 : stall0 + 1'b1);
            stall1 <= !starved1 ? '0 : (stall1 == '1 ? stall1 : stall1 + 1'b1);
        end
    end

    orderCheck: assert property (@(posedge rdclk) disable iff (rdrst)
        outWord.valid |-> outWord.data == expectData)
    else begin
        errors++;
        $error("mismatch at %0t: channel %0d gave %h, expected %h", $time, outWord.tag,
               outWord.data, expectData);
    end

    alternateCheck: assert property (@(posedge rdclk) disable iff (rdrst)
        outWord.valid && expectAlt |-> outWord.tag != lastTag)
    else begin
        errors++;
        $error("mismatch at %0t: channel %0d served twice in a row", $time, lastTag);
    end

    blockCheck: assert property (@(posedge rdclk) disable iff (rdrst)
        outWord.valid && ctrlAge == 2'(BlockDelay) |-> (outWord.tag ? open1 : open0))
    else begin
        errors++;
        $error("mismatch at %0t: word from closed channel %0d", $time, outWord.tag);
    end

    drainCheck: assert property (@(posedge rdclk) disable iff (rdrst)
        stall0 < StallLimit && stall1 < StallLimit)
    else begin
        errors++;
        $error("Open channel stopped delivering its pending words at %0t", $time);
    end

    statusCheck: assert property (@(posedge rdclk) disable iff (rdrst)
        access && !apbIn.pwrite && apbIn.paddr == REG_STATUS && !everEnabled
        |-> apbOut.prdata == {16'(written1), 16'(written0)})
    else begin
        errors++;
        $error("mismatch at %0t: occupancy readback %h", $time, apbOut.prdata);
    end

    countCheck: assert property (@(posedge rdclk) disable iff (rdrst)
        access && !apbIn.pwrite && (apbIn.paddr == REG_COUNT0 || apbIn.paddr == REG_COUNT1)
        |-> apbOut.prdata == 32'(apbIn.paddr == REG_COUNT0 ? seen0 : seen1))
    else begin
        errors++;
        $error("mismatch at %0t: counter readback %h", $time, apbOut.prdata);
    end

    responseCheck: assert property (@(posedge rdclk) disable iff (rdrst)
        access |-> apbOut.pready && apbOut.pslverr == expectErr)
    else begin
        errors++;
        $error("mismatch at %0t: APB response at offset %0d", $time, apbIn.paddr);
    end

endmodule

bind mergeTop mergeCheck u_check (
    .rdclk   (rdclk),
    .rdrst   (rdrst),
    .wrPort0 (wrPort0),
    .wrPort1 (wrPort1),
    .apbIn   (apbIn),
    .apbOut  (apbOut),
    .outWord (outWord)
);

`default_nettype wire

// File: bench/mergeTb.sv
`default_nettype none

module mergeTb;

    timeunit 1ns;
    timeprecision 1ps;

    import fifoPkg::*;
    import apbPkg::*;

    localparam int Fill0          = 12;
    localparam int Fill1          = 14;
    localparam int MaskedWords    = 6;
    localparam int ResumeWords    = 5;
    localparam int TotalWords     = Fill0 + Fill1 + 2 * MaskedWords + ResumeWords;
    localparam int WatchdogCycles = 200 * TotalWords;

    logic        rdclk;
    logic        rdrst;
    fifoWrite_t  wrPort0;
    fifoWrite_t  wrPort1;
    apbReq_t     apbIn;
    apbResp_t    apbOut;
    mergedWord_t outWord;

    logic [31:0] rngState;
    logic [7:0]  seq0;
    logic [7:0]  seq1;
    int          sent0;
    int          sent1;
    int          timeouts = 0;
    logic [31:0] readData;

    mergeTop u_mergeTop (
        .rdclk   (rdclk),
        .rdrst   (rdrst),
        .wrPort0 (wrPort0),
        .wrPort1 (wrPort1),
        .apbIn   (apbIn),
        .apbOut  (apbOut),
        .outWord (outWord)
    );

    initial begin
        rdclk = 1'b0;
        forever begin
            #10 rdclk = ~rdclk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic nextRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value    = rngState;
    endtask

    // One APB transfer with a setup and an access cycle
    // Read data is taken inside the access cycle
    task automatic apbAccess(input logic write, input logic [3:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge rdclk);
        apbIn.psel    = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite  = write;
        apbIn.paddr   = addr;
        apbIn.pwdata  = wdata;
        @(negedge rdclk);
        apbIn.penable = 1'b1;
        #1;
        while (!apbOut.pready) begin
            @(negedge rdclk);
            #1;
        end
        rdata = apbOut.prdata;
        @(negedge rdclk);
        apbIn = '0;
    endtask

    // Low byte carries the running sequence number
    // Upper byte and write gaps are random
    task automatic fillChannels(input int n0, input int n1);
        int          left0;
        int          left1;
        logic [31:0] r;
        left0 = n0;
        left1 = n1;
        while (left0 > 0 || left1 > 0) begin
            @(negedge rdclk);
            nextRandom(r);
            wrPort0 = '0;
            wrPort1 = '0;
            if (left0 > 0 && r[0]) begin
                wrPort0.wrEn = 1'b1;
                wrPort0.data = {r[15:8], seq0};
                seq0++;
                sent0++;
                left0--;
            end
            if (left1 > 0 && r[1]) begin
                wrPort1.wrEn = 1'b1;
                wrPort1.data = {r[23:16], seq1};
                seq1++;
                sent1++;
                left1--;
            end
        end
        @(negedge rdclk);
        wrPort0 = '0;
        wrPort1 = '0;
    endtask

    // Poll the merged-word counters until they reach the given totals
    task automatic waitCounts(input int want0, input int want1);
        logic [31:0] got0;
        logic [31:0] got1;
        do begin
            apbAccess(1'b0, REG_COUNT0, 32'd0, got0);
            apbAccess(1'b0, REG_COUNT1, 32'd0, got1);
        end while (got0 != 32'(want0) || got1 != 32'(want1));
    endtask

    task automatic printSummary();
        $display("Closing report: %0d assertion failures, %0d timeouts",
                 u_mergeTop.u_check.errors, timeouts);
    endtask

    initial begin
        rdrst    = 1'b1;
        wrPort0  = '0;
        wrPort1  = '0;
        apbIn    = '0;
        rngState = 32'hfdc;
        seq0     = '0;
        seq1     = '0;
        sent0    = 0;
        sent1    = 0;
        repeat (5) @(negedge rdclk);
        rdrst = 1'b0;

        // Fill both channels with the merger still off
        fillChannels(Fill0, Fill1);
        repeat (4) @(negedge rdclk);
        apbAccess(1'b0, REG_STATUS, 32'd0, readData);
        apbAccess(1'b0, 4'd5, 32'd0, readData);
        apbAccess(1'b1, 4'd5, 32'd0, readData);
        apbAccess(1'b1, REG_STATUS, 32'd1, readData);

        // Enable with both channels unmasked
        apbAccess(1'b1, REG_CTRL, 32'h7, readData);
        waitCounts(sent0, sent1);

        // Channel 1 masked so its words stay queued
        apbAccess(1'b1, REG_CTRL, 32'h3, readData);
        fillChannels(MaskedWords, MaskedWords);
        waitCounts(sent0, sent1 - MaskedWords);

        // Merger off while channel 0 gets more words
        apbAccess(1'b1, REG_CTRL, 32'h6, readData);
        fillChannels(ResumeWords, 0);
        repeat (20) @(negedge rdclk);

        apbAccess(1'b1, REG_CTRL, 32'h7, readData);
        waitCounts(sent0, sent1);
        repeat (10) @(negedge rdclk);

        printSummary();
        if (u_mergeTop.u_check.errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge rdclk);
        timeouts = 1;
        $display("Timeout: the merged stream did not drain within %0d cycles",
                 WatchdogCycles);
        printSummary();
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/fifoPkg.sv
common/apbPkg.sv
fifo/fifoController.sv
fifo/fifoMemory.sv
fifo/fastFifo.sv
logic/streamMerger.sv
logic/apbRegs.sv
logic/mergeTop.sv
bench/merge_sva.sv
bench/mergeTb.sv
